//--- dv/sys86_video_bus_assert.sv
`timescale 1ns/1ps

module sys86_video_bus_assert (
	input logic clk_48m,
	input logic rst_n,
	input logic m_cyc,
	input logic m_stb,
	input logic m_ack,
	input logic s_cyc,
	input logic s_stb,
	input logic s_ack
);

	////////////////////////////////////////////////////////////
	// wishbone handshake on both ports
	////////////////////////////////////////////////////////////

	// one owner of the shared bus per cycle
	a_ack_exclusive: assert property (@(posedge clk_48m) disable iff (!rst_n)
		!(m_ack && s_ack))
		else $error("m_ack and s_ack high in the same cycle");

	// ack only answers a live request
	a_m_ack_req: assert property (@(posedge clk_48m) disable iff (!rst_n)
		m_ack |-> (m_cyc && m_stb))
		else $error("m_ack raised without m_cyc and m_stb");

	a_s_ack_req: assert property (@(posedge clk_48m) disable iff (!rst_n)
		s_ack |-> (s_cyc && s_stb))
		else $error("s_ack raised without s_cyc and s_stb");

	// single cycle acks
	a_m_ack_pulse: assert property (@(posedge clk_48m) disable iff (!rst_n)
		m_ack |=> !m_ack)
		else $error("m_ack held longer than one cycle");

	a_s_ack_pulse: assert property (@(posedge clk_48m) disable iff (!rst_n)
		s_ack |=> !s_ack)
		else $error("s_ack held longer than one cycle");

endmodule

bind sys86_video_bus sys86_video_bus_assert i_sys86_video_bus_assert (
	.clk_48m (clk_48m),
	.rst_n   (rst_n),
	.m_cyc   (m_cyc),
	.m_stb   (m_stb),
	.m_ack   (m_ack),
	.s_cyc   (s_cyc),
	.s_stb   (s_stb),
	.s_ack   (s_ack)
);

//--- dv/tb_sys86_video_bus.sv
`timescale 1ns/1ps

module tb_sys86_video_bus;

	import sys86_pkg::*;

	localparam bit PORT_M = 1'b0;
	localparam bit PORT_S = 1'b1;
	// random RAM accesses per port, contention rounds
	localparam int N_RAM = 16;
	localparam int N_CONT = 8;
	// slot wait of four dots, then grant and ack
	localparam int ACK_LIMIT = 34;
	localparam int LINE_CYCLES = 3072;
	localparam int ACCESS_COUNT = 4 * N_RAM + 4 + 14 + 4 * N_CONT;
	// reset, eight lines of hsync measurement, every access at its bound, times two
	localparam int CYCLE_LIMIT = 2 * (16 + 8 * LINE_CYCLES + ACCESS_COUNT * ACK_LIMIT);

	logic clk_48m;
	logic rst_n;
	logic m_cyc;
	logic m_stb;
	logic m_we;
	logic [15:0] m_adr;
	logic [7:0] m_dat_w;
	logic [7:0] m_dat_r;
	logic m_ack;
	logic s_cyc;
	logic s_stb;
	logic s_we;
	logic [15:0] s_adr;
	logic [7:0] s_dat_w;
	logic [7:0] s_dat_r;
	logic s_ack;
	logic [DOT_W-1:0] dot_h;
	logic [DOT_W-1:0] dot_v;
	logic hsync;
	logic vsync;
	logic hblank;
	logic vblank;
	logic [7:0] scroll0_x;
	logic [7:0] scroll0_y;
	logic [7:0] scroll1_x;
	logic [7:0] scroll1_y;
	logic [7:0] back_color;

	// scoreboard copy of the 8K video RAM
	logic [7:0] vram_model [0:(2**VRAM_AW)-1];
	int mismatch_errs = 0;
	int other_errs = 0;
	int cycle_cnt = 0;

	sys86_video_bus i_sys86_video_bus (.*);

	////////////////////////////////////////////////////////////
	// clock, timeout, ack monitor
	////////////////////////////////////////////////////////////

	initial begin
		clk_48m = 1'b0;
		forever #5 clk_48m = ~clk_48m;
	end

	always @(posedge clk_48m) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	initial begin
		wait (cycle_cnt >= CYCLE_LIMIT);
		$display("run stopped by timeout after %0d cycles", cycle_cnt);
		$display("errors: %0d mismatch, %0d other", mismatch_errs, other_errs);
		$display("TEST FAIL");
		$finish;
	end

	// ports are two dots apart, acks never overlap
	always @(negedge clk_48m) begin
		if (rst_n) begin
			assert (!(m_ack && s_ack)) else begin
				other_errs++;
				$display("m_ack and s_ack were high in the same cycle");
			end
		end
	end

	////////////////////////////////////////////////////////////
	// bus tasks
	////////////////////////////////////////////////////////////

	task automatic check_byte(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		assert (got === exp) else begin
			mismatch_errs++;
			$display("MISMATCH %s got %02h expected %02h", name, got, exp);
		end
	endtask

	// drive one port's request lines on a falling edge
	task automatic drive_port(input bit port, input bit req, input bit we,
			input logic [15:0] adr, input logic [7:0] dat);
		if (port == PORT_S) begin
			s_cyc = req;
			s_stb = req;
			s_we = we;
			s_adr = adr;
			s_dat_w = dat;
		end else begin
			m_cyc = req;
			m_stb = req;
			m_we = we;
			m_adr = adr;
			m_dat_w = dat;
		end
	endtask

	// hold the request until ack, then release it after the ack edge
	task automatic wait_ack(input bit port, output logic [7:0] dat);
		int waited;
		waited = 0;
		while (!(port == PORT_S ? s_ack : m_ack)) begin
			@(negedge clk_48m);
			waited++;
		end
		dat = (port == PORT_S) ? s_dat_r : m_dat_r;
		assert (waited <= ACK_LIMIT) else begin
			other_errs++;
			$display("ack on port %0d came after %0d cycles, more than %0d",
				port, waited, ACK_LIMIT);
		end
		@(negedge clk_48m);
		drive_port(port, 1'b0, 1'b0, 16'h0000, 8'h00);
	endtask

	task automatic wb_write(input bit port, input logic [15:0] adr, input logic [7:0] dat);
		logic [7:0] unused;
		drive_port(port, 1'b1, 1'b1, adr, dat);
		wait_ack(port, unused);
		// RAM lives below 2000h
		if (adr < 16'h2000)
			vram_model[adr[VRAM_AW-1:0]] = dat;
	endtask

	task automatic wb_read(input bit port, input logic [15:0] adr, output logic [7:0] dat);
		drive_port(port, 1'b1, 1'b0, adr, 8'h00);
		wait_ack(port, dat);
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset();
		check_byte("m_ack", {7'd0, m_ack}, 8'h00);
		check_byte("s_ack", {7'd0, s_ack}, 8'h00);
		check_byte("hsync", {7'd0, hsync}, 8'h00);
		check_byte("vsync", {7'd0, vsync}, 8'h00);
		check_byte("hblank", {7'd0, hblank}, 8'h00);
		check_byte("vblank", {7'd0, vblank}, 8'h00);
		check_byte("scroll0_x", scroll0_x, 8'h00);
		check_byte("scroll0_y", scroll0_y, 8'h00);
		check_byte("scroll1_x", scroll1_x, 8'h00);
		check_byte("scroll1_y", scroll1_y, 8'h00);
		check_byte("back_color", back_color, 8'h00);
		// dot and line counters restart at zero
		assert (dot_h === '0) else begin
			mismatch_errs++;
			$display("MISMATCH dot_h got %h expected %h", dot_h, 9'h000);
		end
		assert (dot_v === '0) else begin
			mismatch_errs++;
			$display("MISMATCH dot_v got %h expected %h", dot_v, 9'h000);
		end
	endtask

	task automatic test_ram_port(input bit port);
		logic [15:0] adr [N_RAM];
		logic [7:0] got;
		for (int i = 0; i < N_RAM; i++) begin
			adr[i] = 16'($urandom % (2 ** VRAM_AW));
			wb_write(port, adr[i], 8'($urandom));
		end
		for (int i = 0; i < N_RAM; i++) begin
			wb_read(port, adr[i], got);
			check_byte(port == PORT_S ? "s_dat_r" : "m_dat_r", got,
				vram_model[adr[i][VRAM_AW-1:0]]);
		end
	endtask

	// one port writes, the other reads back
	task automatic test_shared();
		logic [7:0] got;
		wb_write(PORT_M, 16'h0123, 8'hA5);
		wb_read(PORT_S, 16'h0123, got);
		check_byte("s_dat_r", got, 8'hA5);
		wb_write(PORT_S, 16'h1F00, 8'h3C);
		wb_read(PORT_M, 16'h1F00, got);
		check_byte("m_dat_r", got, 8'h3C);
	endtask

	task automatic test_latches();
		logic [7:0] val [5];
		logic [7:0] got;
		for (int i = 0; i < 5; i++) begin
			val[i] = 8'($urandom);
			wb_write(PORT_M, 16'(LATCH_BASE + i), val[i]);
		end
		check_byte("scroll0_x", scroll0_x, val[0]);
		check_byte("scroll0_y", scroll0_y, val[1]);
		check_byte("scroll1_x", scroll1_x, val[2]);
		check_byte("scroll1_y", scroll1_y, val[3]);
		check_byte("back_color", back_color, val[4]);
		for (int i = 0; i < 5; i++) begin
			wb_read(PORT_S, 16'(LATCH_BASE + i), got);
			check_byte("s_dat_r", got, val[i]);
		end
		// hole in the latch window reads open bus
		wb_read(PORT_M, 16'(LATCH_BASE + 6), got);
		check_byte("m_dat_r", got, 8'hFF);
		// 8000h aliases nothing, RAM 0 and latches keep their values
		wb_write(PORT_M, 16'h0000, 8'h5A);
		wb_write(PORT_M, 16'h8000, ~val[0]);
		wb_read(PORT_S, 16'h0000, got);
		check_byte("s_dat_r", got, 8'h5A);
		check_byte("scroll0_x", scroll0_x, val[0]);
		check_byte("back_color", back_color, val[4]);
	endtask

	// master in the low 4K, sub in the high 4K, reads cross over
	task automatic test_contention();
		logic [15:0] adr_m;
		logic [15:0] adr_s;
		logic [7:0] got_m;
		logic [7:0] got_s;
		for (int r = 0; r < N_CONT; r++) begin
			adr_m = 16'($urandom % 4096);
			adr_s = 16'(4096 + $urandom % 4096);
			fork
				wb_write(PORT_M, adr_m, 8'($urandom));
				wb_write(PORT_S, adr_s, 8'($urandom));
			join
			fork
				wb_read(PORT_M, adr_s, got_m);
				wb_read(PORT_S, adr_m, got_s);
			join
			check_byte("m_dat_r", got_m, vram_model[adr_s[VRAM_AW-1:0]]);
			check_byte("s_dat_r", got_s, vram_model[adr_m[VRAM_AW-1:0]]);
		end
	endtask

	task automatic test_video();
		int gap;
		int edges;
		logic prev_hsync;
		logic [DOT_W-1:0] prev_h;
		logic h_changed;
		gap = 0;
		edges = 0;
		prev_hsync = hsync;
		prev_h = dot_h;
		h_changed = 1'b0;
		while (edges < 4) begin
			@(negedge clk_48m);
			gap++;
			// hblank registered one cycle behind dot_h
			if (h_changed) begin
				assert (hblank == (dot_h >= 288)) else begin
					mismatch_errs++;
					$display("MISMATCH hblank got %h expected %h at dot_h %h",
						hblank, (dot_h >= 288), dot_h);
				end
			end
			h_changed = (dot_h != prev_h);
			prev_h = dot_h;
			if (hsync && !prev_hsync) begin
				if (edges > 0) begin
					assert (gap == LINE_CYCLES) else begin
						mismatch_errs++;
						$display("MISMATCH hsync period got %h expected %h",
							gap, LINE_CYCLES);
					end
				end
				edges++;
				gap = 0;
			end
			prev_hsync = hsync;
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(88));
		rst_n = 1'b0;
		drive_port(PORT_M, 1'b0, 1'b0, 16'h0000, 8'h00);
		drive_port(PORT_S, 1'b0, 1'b0, 16'h0000, 8'h00);
		repeat (16) @(posedge clk_48m);
		@(negedge clk_48m);
		rst_n = 1'b1;
		@(negedge clk_48m);
		test_reset();
		test_ram_port(PORT_M);
		test_ram_port(PORT_S);
		test_shared();
		test_latches();
		test_contention();
		test_video();
		$display("errors: %0d mismatch, %0d other", mismatch_errs, other_errs);
		if (mismatch_errs == 0 && other_errs == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- logic/bus_request_mux.sv
`timescale 1ns/1ps

module bus_request_mux (
	input  logic grant_sub,
	input  logic m_we,
	input  logic [15:0] m_adr,
	input  logic [7:0] m_dat_w,
	input  logic s_we,
	input  logic [15:0] s_adr,
	input  logic [7:0] s_dat_w,
	input  logic bus_en,
	input  logic [7:0] vram_dat_r,
	input  logic [7:0] reg_dat_r,
	output logic [sys86_pkg::VRAM_AW-1:0] bus_adr,
	output logic bus_we,
	output logic [7:0] bus_dat_w,
	output logic vram_sel,
	output logic latch_sel,
	output logic [2:0] latch_idx,
	output logic [7:0] rd_data
);

	import sys86_pkg::*;

	// request of the port that owns the bus
	logic [15:0] sel_adr;
	logic region_vram;
	logic region_latch;

	////////////////////////////////////////////////////////////
	// port select
	////////////////////////////////////////////////////////////

	assign sel_adr = grant_sub ? s_adr : m_adr;
	assign bus_we = grant_sub ? s_we : m_we;
	assign bus_dat_w = grant_sub ? s_dat_w : m_dat_w;
	assign bus_adr = sel_adr[VRAM_AW-1:0];

	////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////

	// video RAM below 2000h
	assign region_vram = (sel_adr[15:VRAM_AW] == '0);
	// eight byte latch window, offsets past 4 read as open bus
	assign region_latch = (sel_adr[15:3] == LATCH_BASE[15:3]);
	assign latch_idx = sel_adr[2:0];

	// selects only live in the grant cycle
	assign vram_sel = bus_en && region_vram;
	assign latch_sel = bus_en && region_latch;

	// address is held by the port until ack, and grant_sub holds through
	// ack too, so the region still steers the data one cycle after grant
	// latch block returns open bus for everything that is not RAM
	assign rd_data = region_vram ? vram_dat_r : reg_dat_r;

endmodule

//--- logic/bus_slot_sequencer.sv
`timescale 1ns/1ps

module bus_slot_sequencer (
	input  logic clk_48m,
	input  logic rst_n,
	input  logic ce_6m,
	input  logic [1:0] dot_slot,
	input  logic m_cyc,
	input  logic m_stb,
	input  logic s_cyc,
	input  logic s_stb,
	input  logic [7:0] rd_data,
	output logic bus_en,
	output logic grant_sub,
	output logic m_ack,
	output logic s_ack,
	output logic [7:0] m_dat_r,
	output logic [7:0] s_dat_r
);

	import sys86_pkg::*;

	seq_state_t state;
	// port that owns the current access, held through ack
	logic serving_sub;
	logic m_req;
	logic s_req;

	assign m_req = m_cyc && m_stb;
	assign s_req = s_cyc && s_stb;

	////////////////////////////////////////////////////////////
	// slot state machine
	////////////////////////////////////////////////////////////

	// ce_6m sees each dot value once, so each slot opens once per 4 dots
	always_ff @(posedge clk_48m or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			serving_sub <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (ce_6m && dot_slot == SLOT_MASTER && m_req) begin
						state <= GRANT_MASTER;
						serving_sub <= 1'b0;
					end else if (ce_6m && dot_slot == SLOT_SUB && s_req) begin
						state <= GRANT_SUB;
						serving_sub <= 1'b1;
					end
				end
				// write lands or reads issue here
				GRANT_MASTER, GRANT_SUB: begin
					state <= ACK;
				end
				// back to idle so a held strobe is not served twice
				ACK: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// one cycle bus strobe to the decoder
	assign bus_en = (state == GRANT_MASTER) || (state == GRANT_SUB);
	assign grant_sub = serving_sub;

	// ack to the owner only, never both
	assign m_ack = (state == ACK) && !serving_sub;
	assign s_ack = (state == ACK) && serving_sub;

	// registered read data is valid in the ack cycle
	assign m_dat_r = m_ack ? rd_data : 8'h00;
	assign s_dat_r = s_ack ? rd_data : 8'h00;

endmodule

//--- logic/scroll_latches.sv
`timescale 1ns/1ps

module scroll_latches (
	input  logic clk_48m,
	input  logic rst_n,
	input  logic latch_sel,
	input  logic bus_we,
	input  logic [2:0] latch_idx,
	input  logic [7:0] bus_dat_w,
	output logic [7:0] reg_dat_r,
	output logic [7:0] scroll0_x,
	output logic [7:0] scroll0_y,
	output logic [7:0] scroll1_x,
	output logic [7:0] scroll1_y,
	output logic [7:0] back_color
);

	import sys86_pkg::*;

	////////////////////////////////////////////////////////////
	// latch writes
	////////////////////////////////////////////////////////////

	// offsets 0..4, others dropped
	always_ff @(posedge clk_48m or negedge rst_n) begin
		if (!rst_n) begin
			scroll0_x <= 8'h00;
			scroll0_y <= 8'h00;
			scroll1_x <= 8'h00;
			scroll1_y <= 8'h00;
			back_color <= 8'h00;
		end else if (latch_sel && bus_we) begin
			case (latch_idx)
				3'd0: scroll0_x <= bus_dat_w;
				3'd1: scroll0_y <= bus_dat_w;
				3'd2: scroll1_x <= bus_dat_w;
				3'd3: scroll1_y <= bus_dat_w;
				3'd4: back_color <= bus_dat_w;
				default: ;
			endcase
		end
	end

	// readback one cycle later, open bus when idle or unmapped
	always_ff @(posedge clk_48m or negedge rst_n) begin
		if (!rst_n) begin
			reg_dat_r <= UNMAPPED_DATA;
		end else if (latch_sel && !bus_we) begin
			case (latch_idx)
				3'd0: reg_dat_r <= scroll0_x;
				3'd1: reg_dat_r <= scroll0_y;
				3'd2: reg_dat_r <= scroll1_x;
				3'd3: reg_dat_r <= scroll1_y;
				3'd4: reg_dat_r <= back_color;
				default: reg_dat_r <= UNMAPPED_DATA;
			endcase
		end else begin
			reg_dat_r <= UNMAPPED_DATA;
		end
	end

endmodule

//--- logic/shared_vram.sv
`timescale 1ns/1ps

module shared_vram (
	input  logic clk_48m,
	input  logic vram_sel,
	input  logic bus_we,
	input  logic [sys86_pkg::VRAM_AW-1:0] bus_adr,
	input  logic [7:0] bus_dat_w,
	output logic [7:0] vram_dat_r
);

	import sys86_pkg::*;

	// shared tile and sprite RAM, one port
	logic [7:0] mem [0:(2**VRAM_AW)-1];

	////////////////////////////////////////////////////////////
	// single port access
	////////////////////////////////////////////////////////////

	// write on select with we
	always_ff @(posedge clk_48m) begin
		if (vram_sel && bus_we)
			mem[bus_adr] <= bus_dat_w;
	end

	// registered read, valid the cycle after select
	always_ff @(posedge clk_48m) begin
		if (vram_sel && !bus_we)
			vram_dat_r <= mem[bus_adr];
	end

endmodule

//--- logic/sys86_pkg.sv
package sys86_pkg;

	////////////////////////////////////////////////////////////
	// video timing
	////////////////////////////////////////////////////////////

	// clk_48m cycles per 6 MHz dot
	localparam int CLK_DIV = 8;

	// dots per line, lines per frame
	localparam int H_TOTAL = 384;
	localparam int V_TOTAL = 264;

	// blanking starts at these counts
	localparam int H_VISIBLE = 288;
	localparam int V_VISIBLE = 224;

	// active high sync windows, start inclusive, end exclusive
	localparam int HSYNC_START = 304;
	localparam int HSYNC_END = 336;
	localparam int VSYNC_START = 240;
	localparam int VSYNC_END = 243;

	// dot and line counter width
	localparam int DOT_W = 9;

	////////////////////////////////////////////////////////////
	// address map
	////////////////////////////////////////////////////////////

	// 8K x 8 video RAM
	localparam int VRAM_AW = 13;

	// scroll0_x/y, scroll1_x/y, back_color at offsets 0..4
	localparam logic [15:0] LATCH_BASE = 16'h2000;

	// open bus value
	localparam logic [7:0] UNMAPPED_DATA = 8'hFF;

	////////////////////////////////////////////////////////////
	// bus slots
	////////////////////////////////////////////////////////////

	// low two dot bits that open each port's slot
	localparam logic [1:0] SLOT_MASTER = 2'd0;
	localparam logic [1:0] SLOT_SUB = 2'd2;

	// sequencer states
	typedef enum logic [1:0] {
		IDLE,
		GRANT_MASTER,
		GRANT_SUB,
		ACK
	} seq_state_t;

endpackage

//--- logic/sys86_video_bus.sv
`timescale 1ns/1ps

module sys86_video_bus (
	input  logic clk_48m,
	input  logic rst_n,
	// master CPU port
	input  logic m_cyc,
	input  logic m_stb,
	input  logic m_we,
	input  logic [15:0] m_adr,
	input  logic [7:0] m_dat_w,
	output logic [7:0] m_dat_r,
	output logic m_ack,
	// sub CPU port
	input  logic s_cyc,
	input  logic s_stb,
	input  logic s_we,
	input  logic [15:0] s_adr,
	input  logic [7:0] s_dat_w,
	output logic [7:0] s_dat_r,
	output logic s_ack,
	// video timing
	output logic [sys86_pkg::DOT_W-1:0] dot_h,
	output logic [sys86_pkg::DOT_W-1:0] dot_v,
	output logic hsync,
	output logic vsync,
	output logic hblank,
	output logic vblank,
	// latches
	output logic [7:0] scroll0_x,
	output logic [7:0] scroll0_y,
	output logic [7:0] scroll1_x,
	output logic [7:0] scroll1_y,
	output logic [7:0] back_color
);

	import sys86_pkg::*;

	logic ce_6m;
	logic bus_en;
	logic grant_sub;
	logic [VRAM_AW-1:0] bus_adr;
	logic bus_we;
	logic [7:0] bus_dat_w;
	logic vram_sel;
	logic latch_sel;
	logic [2:0] latch_idx;
	logic [7:0] vram_dat_r;
	logic [7:0] reg_dat_r;
	logic [7:0] rd_data;

	////////////////////////////////////////////////////////////
	// timing and arbitration
	////////////////////////////////////////////////////////////

	video_timing i_video_timing (
		.clk_48m (clk_48m),
		.rst_n   (rst_n),
		.ce_6m   (ce_6m),
		.dot_h   (dot_h),
		.dot_v   (dot_v),
		.hsync   (hsync),
		.vsync   (vsync),
		.hblank  (hblank),
		.vblank  (vblank)
	);

	// slots keyed on the two low dot bits
	bus_slot_sequencer i_bus_slot_sequencer (
		.clk_48m   (clk_48m),
		.rst_n     (rst_n),
		.ce_6m     (ce_6m),
		.dot_slot  (dot_h[1:0]),
		.m_cyc     (m_cyc),
		.m_stb     (m_stb),
		.s_cyc     (s_cyc),
		.s_stb     (s_stb),
		.rd_data   (rd_data),
		.bus_en    (bus_en),
		.grant_sub (grant_sub),
		.m_ack     (m_ack),
		.s_ack     (s_ack),
		.m_dat_r   (m_dat_r),
		.s_dat_r   (s_dat_r)
	);

	bus_request_mux i_bus_request_mux (
		.grant_sub  (grant_sub),
		.m_we       (m_we),
		.m_adr      (m_adr),
		.m_dat_w    (m_dat_w),
		.s_we       (s_we),
		.s_adr      (s_adr),
		.s_dat_w    (s_dat_w),
		.bus_en     (bus_en),
		.vram_dat_r (vram_dat_r),
		.reg_dat_r  (reg_dat_r),
		.bus_adr    (bus_adr),
		.bus_we     (bus_we),
		.bus_dat_w  (bus_dat_w),
		.vram_sel   (vram_sel),
		.latch_sel  (latch_sel),
		.latch_idx  (latch_idx),
		.rd_data    (rd_data)
	);

	////////////////////////////////////////////////////////////
	// shared targets
	////////////////////////////////////////////////////////////

	shared_vram i_shared_vram (
		.clk_48m    (clk_48m),
		.vram_sel   (vram_sel),
		.bus_we     (bus_we),
		.bus_adr    (bus_adr),
		.bus_dat_w  (bus_dat_w),
		.vram_dat_r (vram_dat_r)
	);

	scroll_latches i_scroll_latches (
		.clk_48m    (clk_48m),
		.rst_n      (rst_n),
		.latch_sel  (latch_sel),
		.bus_we     (bus_we),
		.latch_idx  (latch_idx),
		.bus_dat_w  (bus_dat_w),
		.reg_dat_r  (reg_dat_r),
		.scroll0_x  (scroll0_x),
		.scroll0_y  (scroll0_y),
		.scroll1_x  (scroll1_x),
		.scroll1_y  (scroll1_y),
		.back_color (back_color)
	);

endmodule

//--- logic/video_timing.sv
`timescale 1ns/1ps

module video_timing (
	input  logic clk_48m,
	input  logic rst_n,
	output logic ce_6m,
	output logic [sys86_pkg::DOT_W-1:0] dot_h,
	output logic [sys86_pkg::DOT_W-1:0] dot_v,
	output logic hsync,
	output logic vsync,
	output logic hblank,
	output logic vblank
);

	import sys86_pkg::*;

	// prescaler count within one dot
	logic [$clog2(CLK_DIV)-1:0] div_cnt;

	////////////////////////////////////////////////////////////
	// dot enable
	////////////////////////////////////////////////////////////

	// one clk_48m pulse per CLK_DIV cycles
	always_ff @(posedge clk_48m or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			ce_6m <= 1'b0;
		end else begin
			if (div_cnt == CLK_DIV - 1) begin
				div_cnt <= '0;
				ce_6m <= 1'b1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
				ce_6m <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// dot and line counters
	////////////////////////////////////////////////////////////

	// line counter steps when the dot counter wraps
	always_ff @(posedge clk_48m or negedge rst_n) begin
		if (!rst_n) begin
			dot_h <= '0;
			dot_v <= '0;
		end else if (ce_6m) begin
			if (dot_h == H_TOTAL - 1) begin
				dot_h <= '0;
				if (dot_v == V_TOTAL - 1)
					dot_v <= '0;
				else
					dot_v <= dot_v + 1'b1;
			end else begin
				dot_h <= dot_h + 1'b1;
			end
		end
	end

	// sync and blank follow the counters one clock later
	always_ff @(posedge clk_48m or negedge rst_n) begin
		if (!rst_n) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			hblank <= 1'b0;
			vblank <= 1'b0;
		end else begin
			hsync <= (dot_h >= HSYNC_START) && (dot_h < HSYNC_END);
			vsync <= (dot_v >= VSYNC_START) && (dot_v < VSYNC_END);
			hblank <= (dot_h >= H_VISIBLE);
			vblank <= (dot_v >= V_VISIBLE);
		end
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sys86_video_bus -f sys86_video_bus.f -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "build or simulation run failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -qx "TEST PASS" sim.log &&
echo "result: passed" ||
{ echo "result: failed"; exit 1; }

//--- sys86_video_bus.f
logic/sys86_pkg.sv
logic/video_timing.sv
logic/bus_slot_sequencer.sv
logic/bus_request_mux.sv
logic/shared_vram.sv
logic/scroll_latches.sv
logic/sys86_video_bus.sv
dv/sys86_video_bus_assert.sv
dv/tb_sys86_video_bus.sv
